// ==== filelist.f ====
source/mmu_pkg.sv
source/mmu_tlb.sv
source/mmu_fetch_xlate.sv
source/mmu_data_xlate.sv
source/mmu_refill_arbiter.sv
source/mmu_top.sv
verification/mmu_sva.sv
verification/mmu_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module mmu_tb -Mdir obj_dir -o mmu_sim
	out=$$(./obj_dir/mmu_sim); echo "$$out"; \
		echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// ==== verification/mmu_tb.sv ====
// testbench for the Sv32 MMU with a page-table model and a random-latency walker
`timescale 1ns/1ns
`default_nettype none

module mmu_tb import mmu_pkg::*; ();

  localparam int NUM_REQ = 116;

  logic        clk_i, rst_ni, flush_i, fetch_en_i, ldst_en_i, sum_i;
  priv_lvl_t   priv_i, ldst_priv_i;
  logic        fetch_req_i, lsu_req_i, lsu_is_store_i;
  vaddr_t      fetch_vaddr_i, lsu_vaddr_i;
  logic        fetch_valid_o, lsu_dtlb_hit_o, lsu_valid_o;
  paddr_t      fetch_paddr_o, lsu_dtlb_paddr_o, lsu_paddr_o;
  ppn_t        lsu_dtlb_ppn_o;
  exception_t  fetch_ex_o, lsu_ex_o;
  refill_req_t refill_req_o;
  refill_rsp_t refill_rsp_i;

  logic [31:0] seed, gen;
  int          err_cnt, check_cnt, test_err, test_chk, walk_wait;
  logic        walk_busy, watch_first, first_instr;

  mmu_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // random numbers and page-table model
  // ------------------------------------------------------------
  function automatic logic [31:0] rnd();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed ^ (seed >> 13);
  endfunction

  function automatic logic [31:0] mix(input logic [31:0] x);
    x = x ^ (x >> 16);
    x = x * 32'h045d9f3b;
    return x ^ (x >> 16);
  endfunction

  // megapage choice depends on VPN[1] only, so every VPN under it agrees
  function automatic refill_rsp_t walk_model(input vpn_t vpn);
    logic [31:0] h1, h;
    vpn_t        key;
    refill_rsp_t r;
    h1  = mix({22'd0, vpn[19:10]} ^ gen);
    key = h1[3] ? {vpn[19:10], 10'd0} : vpn;
    h   = mix({12'd0, key} ^ (gen << 20) ^ 32'h5a5a);
    r   = '0;
    r.valid        = 1'b1;
    r.is_mega      = h1[3];
    r.access_fault = (h[2:0] == 3'd0);
    r.page_fault   = (h[2:0] == 3'd1);
    r.pte.ppn      = {h[31:24], h[13:0]};
    r.pte.d        = h[14] | h[15];
    r.pte.u        = h[16];
    r.pte.x        = h[17] | h[18];
    r.pte.w        = h[19];
    r.pte.r        = h[20] | h[21];
    r.pte.a        = 1'b1;
    r.pte.v        = 1'b1;
    return r;
  endfunction

  function automatic paddr_t expect_paddr(input refill_rsp_t r, input vaddr_t va);
    if (r.is_mega) return {r.pte.ppn[21:10], va[21:0]};
    return {r.pte.ppn, va[11:0]};
  endfunction

  // mode 0 any, 1 walk succeeds, 2 walk fails
  function automatic vaddr_t pick_vaddr(input int mode);
    logic [31:0] r;
    vaddr_t      va;
    refill_rsp_t m;
    for (int i = 0; i < 64; i++) begin
      r  = rnd();
      va = {10'h040 + {8'd0, r[1:0]}, 7'd0, r[4:2], r[16:5]};
      m  = walk_model(va[31:12]);
      if (mode == 0) return va;
      if ((mode == 1) == !(m.access_fault || m.page_fault)) return va;
    end
    return va;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    test_chk++;
    if (exp !== got) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
      test_err++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("Error at %0t ns: %s", $time, what);
    test_err++;
  endtask

  // ------------------------------------------------------------
  // request drivers with expected values
  // ------------------------------------------------------------
  task automatic run_fetch(input vaddr_t va, input priv_lvl_t p);
    int          lat;
    logic        perm;
    refill_rsp_t m;
    exception_t  ex;
    @(posedge clk_i);
    fetch_req_i   <= 1'b1;
    fetch_vaddr_i <= va;
    priv_i        <= p;
    lat = 0;
    forever begin
      @(negedge clk_i);
      if (fetch_valid_o || lat > 200) break;
      @(posedge clk_i);
      lat++;
    end
    m  = walk_model(va[31:12]);
    ex = '0;
    if (!fetch_valid_o) begin
      report_problem("fetch request never completed");
    end else if (!fetch_en_i) begin
      if (lat != 0) report_problem("fetch with translation off was not answered at once");
      check_val("fetch_paddr_o", 64'({2'b00, va}), 64'(fetch_paddr_o));
      check_val("fetch_ex_o", 64'(ex), 64'(fetch_ex_o));
    end else begin
      perm = !m.pte.x || (p == PRIV_U && !m.pte.u) || (p == PRIV_S && m.pte.u);
      if (m.access_fault) ex = '{valid: 1'b1, cause: CAUSE_INSTR_ACCESS, tval: va};
      else if (m.page_fault || perm) ex = '{valid: 1'b1, cause: CAUSE_INSTR_PAGE, tval: va};
      check_val("fetch_ex_o", 64'(ex), 64'(fetch_ex_o));
      if (!ex.valid) check_val("fetch_paddr_o", 64'(expect_paddr(m, va)), 64'(fetch_paddr_o));
    end
    @(posedge clk_i);
    fetch_req_i <= 1'b0;
  endtask

  task automatic run_data(input vaddr_t va, input logic st, input priv_lvl_t p, input logic s);
    int          lat;
    logic        perm, c0_hit, walk_ok;
    paddr_t      c0_pa, exp_pa;
    ppn_t        c0_ppn;
    refill_rsp_t m;
    exception_t  ex;
    @(posedge clk_i);
    lsu_req_i      <= 1'b1;
    lsu_vaddr_i    <= va;
    lsu_is_store_i <= st;
    ldst_priv_i    <= p;
    sum_i          <= s;
    lat    = 0;
    c0_hit = 1'b0;
    c0_pa  = '0;
    c0_ppn = '0;
    forever begin
      @(negedge clk_i);
      if ((lat > 0 && lsu_valid_o) || lat > 200) break;
      c0_hit = lsu_dtlb_hit_o;
      c0_pa  = lsu_dtlb_paddr_o;
      c0_ppn = lsu_dtlb_ppn_o;
      @(posedge clk_i);
      lat++;
    end
    m       = walk_model(va[31:12]);
    walk_ok = !(m.access_fault || m.page_fault);
    exp_pa  = expect_paddr(m, va);
    ex      = '0;
    if (!lsu_valid_o) begin
      report_problem("data request never completed");
    end else if (!ldst_en_i) begin
      if (lat != 1) report_problem("data with translation off did not take one cycle");
      check_val("lsu_paddr_o", 64'({2'b00, va}), 64'(lsu_paddr_o));
      check_val("lsu_dtlb_paddr_o", 64'({2'b00, va}), 64'(c0_pa));
      check_val("lsu_dtlb_ppn_o", 64'(va[31:12]), 64'(c0_ppn));
      check_val("lsu_ex_o", 64'(ex), 64'(lsu_ex_o));
    end else begin
      perm = (p == PRIV_S && m.pte.u && !s) || (p == PRIV_U && !m.pte.u)
             || (st ? (!m.pte.w || !m.pte.d) : !m.pte.r);
      if (m.access_fault) begin
        ex = '{valid: 1'b1, cause: st ? CAUSE_STORE_ACCESS : CAUSE_LOAD_ACCESS, tval: va};
      end else if (m.page_fault || perm) begin
        ex = '{valid: 1'b1, cause: st ? CAUSE_STORE_PAGE : CAUSE_LOAD_PAGE, tval: va};
      end
      check_val("lsu_ex_o", 64'(ex), 64'(lsu_ex_o));
      if (!ex.valid) begin
        check_val("lsu_paddr_o", 64'(exp_pa), 64'(lsu_paddr_o));
      end
      // last cycle-0 lookup hits after a good walk and misses before a walk error
      check_val("lsu_dtlb_hit_o", 64'(walk_ok), 64'(c0_hit));
      if (walk_ok) begin
        check_val("lsu_dtlb_paddr_o", 64'(exp_pa), 64'(c0_pa));
        check_val("lsu_dtlb_ppn_o", 64'(exp_pa[PADDR_W-1:PAGE_OFS_W]), 64'(c0_ppn));
      end
    end
    @(posedge clk_i);
    lsu_req_i <= 1'b0;
  endtask

  task automatic random_data(input int mode);
    logic [31:0] r;
    r = rnd();
    run_data(pick_vaddr(mode), r[0], r[1] ? PRIV_S : PRIV_U, r[2]);
  endtask

  task automatic flush_tlbs();
    @(posedge clk_i);
    flush_i <= 1'b1;
    gen = gen + 32'd1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name, test_chk, test_err);
    err_cnt   += test_err;
    check_cnt += test_chk;
    test_err  = 0;
    test_chk  = 0;
  endtask

  // walker answers each held request after 1 to 4 cycles
  always @(posedge clk_i) begin
    if (refill_rsp_i.valid) begin
      refill_rsp_i <= '0;
    end else if (refill_req_o.valid) begin
      if (!walk_busy) begin
        walk_busy = 1'b1;
        walk_wait = 1 + int'(rnd() % 4);
        if (watch_first) begin
          first_instr = refill_req_o.is_instr;
          watch_first = 1'b0;
        end
      end else begin
        walk_wait--;
        if (walk_wait == 0) begin
          refill_rsp_i <= walk_model(refill_req_o.vpn);
          walk_busy = 1'b0;
        end
      end
    end
  end

  // watchdog
  initial begin
    repeat (NUM_REQ * 40) @(posedge clk_i);
    $display("Error: simulation timed out");
    $display("Result: FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    seed = 32'h8745;
    gen = 32'd1;
    {err_cnt, check_cnt, test_err, test_chk, walk_wait} = '0;
    {walk_busy, watch_first, first_instr} = '0;
    {rst_ni, flush_i, fetch_en_i, ldst_en_i, sum_i} = '0;
    {fetch_req_i, lsu_req_i, lsu_is_store_i} = '0;
    priv_i = PRIV_S;
    ldst_priv_i = PRIV_S;
    fetch_vaddr_i = '0;
    lsu_vaddr_i = '0;
    refill_rsp_i = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    repeat (8) run_fetch(rnd(), PRIV_S);
    repeat (8) random_data(0);
    end_test(1, "translation off");

    @(posedge clk_i);
    fetch_en_i <= 1'b1;
    ldst_en_i  <= 1'b1;
    repeat (24) run_fetch(pick_vaddr(1), rnd() % 2 == 0 ? PRIV_U : PRIV_S);
    end_test(2, "fetch translation");

    repeat (32) random_data(1);
    end_test(3, "load and store translation");

    repeat (8) run_fetch(pick_vaddr(2), PRIV_S);
    repeat (8) random_data(2);
    end_test(4, "walk errors");

    repeat (6) begin
      flush_tlbs();
      watch_first = 1'b1;
      fork
        run_fetch(pick_vaddr(0), PRIV_S);
        random_data(0);
      join
      if (!first_instr) report_problem("first refill after a double miss was not for fetch");
    end
    end_test(5, "simultaneous misses");

    flush_tlbs();
    repeat (8) run_fetch(pick_vaddr(0), PRIV_U);
    repeat (8) random_data(0);
    end_test(6, "flush and new table");

    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/mmu_sva.sv ====
// refill handshake and reset-state assertions, bound into the refill arbiter
`timescale 1ns/1ns
`default_nettype none

module mmu_sva
  import mmu_pkg::*;
(
  input wire         clk_i,
  input wire         rst_ni,
  input refill_req_t refill_req_o,
  input refill_rsp_t refill_rsp_i,
  input tlb_update_t itlb_update_o,
  input walk_err_t   iwalk_err_o
);

  // request held with stable vpn and kind until the response pulse
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_req_o.valid && !refill_rsp_i.valid |=>
      refill_req_o.valid && $stable(refill_req_o.vpn) && $stable(refill_req_o.is_instr))
    else $error("refill request changed before its response");

  // no request in the first cycle out of reset
  reset_idle_a: assert property (@(posedge clk_i) $rose(rst_ni) |-> !refill_req_o.valid)
    else $error("refill request raised right after reset");

  // itlb results follow an instruction refill response and never come as a pair
  one_result_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    itlb_update_o.valid || iwalk_err_o.valid |->
      !(itlb_update_o.valid && iwalk_err_o.valid)
      && refill_rsp_i.valid && refill_req_o.valid && refill_req_o.is_instr
      && (iwalk_err_o.valid == (refill_rsp_i.page_fault || refill_rsp_i.access_fault)))
    else $error("itlb update or walk error does not match the refill response");

endmodule

bind mmu_refill_arbiter mmu_sva sva_i (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .refill_req_o  (refill_req_o),
  .refill_rsp_i  (refill_rsp_i),
  .itlb_update_o (itlb_update_o),
  .iwalk_err_o   (iwalk_err_o)
);

`default_nettype wire

// ==== source/mmu_top.sv ====
// Sv32 MMU top level with fetch and data translation paths and a shared refill port
`timescale 1ns/1ns
`default_nettype none

module mmu_top
  import mmu_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_ni,
  input  logic        flush_i,
  input  logic        fetch_en_i,
  input  logic        ldst_en_i,
  input  priv_lvl_t   priv_i,
  input  priv_lvl_t   ldst_priv_i,
  input  logic        sum_i,
  // fetch
  input  logic        fetch_req_i,
  input  vaddr_t      fetch_vaddr_i,
  output logic        fetch_valid_o,
  output paddr_t      fetch_paddr_o,
  output exception_t  fetch_ex_o,
  // load/store
  input  logic        lsu_req_i,
  input  vaddr_t      lsu_vaddr_i,
  input  logic        lsu_is_store_i,
  output logic        lsu_dtlb_hit_o,
  output ppn_t        lsu_dtlb_ppn_o,
  output paddr_t      lsu_dtlb_paddr_o,
  output logic        lsu_valid_o,
  output paddr_t      lsu_paddr_o,
  output exception_t  lsu_ex_o,
  // external walker
  output refill_req_t refill_req_o,
  input  refill_rsp_t refill_rsp_i
);

  miss_t       imiss, dmiss;
  tlb_update_t itlb_update, dtlb_update;
  walk_err_t   iwalk_err, dwalk_err;

  mmu_fetch_xlate i_fetch (
    .clk_i, .rst_ni, .flush_i,
    .en_i          (fetch_en_i),
    .priv_i        (priv_i),
    .fetch_req_i, .fetch_vaddr_i,
    .update_i      (itlb_update),
    .walk_err_i    (iwalk_err),
    .miss_o        (imiss),
    .fetch_valid_o, .fetch_paddr_o, .fetch_ex_o
  );

  mmu_data_xlate i_data (
    .clk_i, .rst_ni, .flush_i,
    .en_i          (ldst_en_i),
    .priv_i        (ldst_priv_i),
    .sum_i,
    .lsu_req_i, .lsu_vaddr_i, .lsu_is_store_i,
    .update_i      (dtlb_update),
    .walk_err_i    (dwalk_err),
    .miss_o        (dmiss),
    .lsu_dtlb_hit_o, .lsu_dtlb_ppn_o, .lsu_dtlb_paddr_o,
    .lsu_valid_o, .lsu_paddr_o, .lsu_ex_o
  );

  mmu_refill_arbiter i_arbiter (
    .clk_i, .rst_ni, .flush_i,
    .imiss_i       (imiss),
    .dmiss_i       (dmiss),
    .refill_req_o, .refill_rsp_i,
    .itlb_update_o (itlb_update),
    .dtlb_update_o (dtlb_update),
    .iwalk_err_o   (iwalk_err),
    .dwalk_err_o   (dwalk_err)
  );

endmodule

`default_nettype wire

// ==== source/mmu_refill_arbiter.sv ====
// serializes ITLB and DTLB misses onto the refill port and routes the response
`timescale 1ns/1ns
`default_nettype none

module mmu_refill_arbiter
  import mmu_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_ni,
  input  logic        flush_i,
  input  miss_t       imiss_i,
  input  miss_t       dmiss_i,
  output refill_req_t refill_req_o,
  input  refill_rsp_t refill_rsp_i,
  output tlb_update_t itlb_update_o,
  output tlb_update_t dtlb_update_o,
  output walk_err_t   iwalk_err_o,
  output walk_err_t   dwalk_err_o
);

  refill_state_e state_q, state_d;
  logic          discard_q, discard_d;
  vpn_t          vpn_q;
  logic          rsp_ok;
  logic          rsp_err;

  // ------------------------------------------------------------
  // FSM, instruction misses first
  // ------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    discard_d = discard_q || flush_i;
    case (state_q)
      IDLE: begin
        discard_d = flush_i;
        if (imiss_i.valid) begin
          state_d = WAIT_I;
        end else if (dmiss_i.valid) begin
          state_d = WAIT_D;
        end
      end
      WAIT_I, WAIT_D: begin
        if (refill_rsp_i.valid) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      discard_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      discard_q <= discard_d;
    end
  end

  // vpn of the miss being served
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE) begin
      vpn_q <= imiss_i.valid ? imiss_i.vpn : dmiss_i.vpn;
    end
  end

  assign refill_req_o.valid    = (state_q != IDLE);
  assign refill_req_o.is_instr = (state_q == WAIT_I);
  assign refill_req_o.vpn      = vpn_q;

  // ------------------------------------------------------------
  // response routing
  // ------------------------------------------------------------
  // a flush during the walk drops the answer
  assign rsp_ok  = refill_rsp_i.valid && !discard_q && !flush_i;
  assign rsp_err = refill_rsp_i.access_fault || refill_rsp_i.page_fault;

  assign itlb_update_o.valid   = rsp_ok && !rsp_err && (state_q == WAIT_I);
  assign itlb_update_o.vpn     = vpn_q;
  assign itlb_update_o.is_mega = refill_rsp_i.is_mega;
  assign itlb_update_o.pte     = refill_rsp_i.pte;

  assign dtlb_update_o.valid   = rsp_ok && !rsp_err && (state_q == WAIT_D);
  assign dtlb_update_o.vpn     = vpn_q;
  assign dtlb_update_o.is_mega = refill_rsp_i.is_mega;
  assign dtlb_update_o.pte     = refill_rsp_i.pte;

  // access fault wins over page fault
  assign iwalk_err_o.valid        = rsp_ok && rsp_err && (state_q == WAIT_I);
  assign iwalk_err_o.access_fault = refill_rsp_i.access_fault;
  assign iwalk_err_o.page_fault   = refill_rsp_i.page_fault && !refill_rsp_i.access_fault;

  assign dwalk_err_o.valid        = rsp_ok && rsp_err && (state_q == WAIT_D);
  assign dwalk_err_o.access_fault = refill_rsp_i.access_fault;
  assign dwalk_err_o.page_fault   = refill_rsp_i.page_fault && !refill_rsp_i.access_fault;

endmodule

`default_nettype wire

// ==== source/mmu_data_xlate.sv ====
// data-side translation with DTLB, cycle-0 hit outputs and cycle-1 checked result
`timescale 1ns/1ns
`default_nettype none

module mmu_data_xlate
  import mmu_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_ni,
  input  logic        flush_i,
  input  logic        en_i,
  input  priv_lvl_t   priv_i,
  input  logic        sum_i,
  input  logic        lsu_req_i,
  input  vaddr_t      lsu_vaddr_i,
  input  logic        lsu_is_store_i,
  input  tlb_update_t update_i,
  input  walk_err_t   walk_err_i,
  output miss_t       miss_o,
  output logic        lsu_dtlb_hit_o,
  output ppn_t        lsu_dtlb_ppn_o,
  output paddr_t      lsu_dtlb_paddr_o,
  output logic        lsu_valid_o,
  output paddr_t      lsu_paddr_o,
  output exception_t  lsu_ex_o
);

  logic      dtlb_hit;
  pte_t      dtlb_pte;
  logic      dtlb_mega;
  logic      req_q;
  logic      hit_q;
  walk_err_t err_q;
  logic      store_q;
  logic      mega_q;
  pte_t      pte_q;
  vaddr_t    vaddr_q;
  logic      perm_err;

  mmu_tlb #(
    .ENTRIES (DTLB_ENTRIES)
  ) i_dtlb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .update_i     (update_i),
    .lu_vaddr_i   (lsu_vaddr_i),
    .lu_hit_o     (dtlb_hit),
    .lu_pte_o     (dtlb_pte),
    .lu_is_mega_o (dtlb_mega)
  );

  // the cycle after a walk error delivers that error, so no new miss is raised
  assign miss_o.valid = lsu_req_i && en_i && !dtlb_hit && !err_q.valid;
  assign miss_o.vpn   = lsu_vaddr_i[VADDR_W-1:PAGE_OFS_W];

  // ------------------------------------------------------------
  // cycle 0
  // ------------------------------------------------------------
  assign lsu_dtlb_hit_o   = en_i ? dtlb_hit : 1'b1;
  assign lsu_dtlb_paddr_o = en_i ? sv32_paddr(dtlb_pte.ppn, dtlb_mega, lsu_vaddr_i)
                                 : PADDR_W'(lsu_vaddr_i);
  assign lsu_dtlb_ppn_o   = lsu_dtlb_paddr_o[PADDR_W-1:PAGE_OFS_W];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      hit_q <= 1'b0;
      err_q <= '0;
    end else begin
      req_q       <= lsu_req_i;
      hit_q       <= dtlb_hit;
      err_q       <= walk_err_i;
      err_q.valid <= walk_err_i.valid && lsu_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    store_q <= lsu_is_store_i;
    mega_q  <= dtlb_mega;
    pte_q   <= dtlb_pte;
    vaddr_q <= lsu_vaddr_i;
  end

  // ------------------------------------------------------------
  // cycle 1
  // ------------------------------------------------------------
  assign perm_err = ((priv_i == PRIV_S) && pte_q.u && !sum_i)
                    || ((priv_i == PRIV_U) && !pte_q.u)
                    || (store_q ? (!pte_q.w || !pte_q.d) : !pte_q.r);

  always_comb begin
    lsu_valid_o = req_q;
    lsu_paddr_o = PADDR_W'(vaddr_q);
    lsu_ex_o    = '0;
    if (en_i) begin
      lsu_valid_o = req_q && (hit_q || err_q.valid);
      lsu_paddr_o = sv32_paddr(pte_q.ppn, mega_q, vaddr_q);
      if (req_q && hit_q && perm_err) begin
        lsu_ex_o.valid = 1'b1;
        lsu_ex_o.cause = store_q ? CAUSE_STORE_PAGE : CAUSE_LOAD_PAGE;
        lsu_ex_o.tval  = vaddr_q;
      end else if (req_q && err_q.valid) begin
        lsu_ex_o.valid = 1'b1;
        if (err_q.access_fault) begin
          lsu_ex_o.cause = store_q ? CAUSE_STORE_ACCESS : CAUSE_LOAD_ACCESS;
        end else begin
          lsu_ex_o.cause = store_q ? CAUSE_STORE_PAGE : CAUSE_LOAD_PAGE;
        end
        lsu_ex_o.tval = vaddr_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/mmu_fetch_xlate.sv ====
// instruction-side translation with ITLB, same-cycle address and permission check
`timescale 1ns/1ns
`default_nettype none

module mmu_fetch_xlate
  import mmu_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_ni,
  input  logic        flush_i,
  input  logic        en_i,
  input  priv_lvl_t   priv_i,
  input  logic        fetch_req_i,
  input  vaddr_t      fetch_vaddr_i,
  input  tlb_update_t update_i,
  input  walk_err_t   walk_err_i,
  output miss_t       miss_o,
  output logic        fetch_valid_o,
  output paddr_t      fetch_paddr_o,
  output exception_t  fetch_ex_o
);

  logic itlb_hit;
  pte_t itlb_pte;
  logic itlb_mega;
  logic perm_err;

  mmu_tlb #(
    .ENTRIES (ITLB_ENTRIES)
  ) i_itlb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .update_i     (update_i),
    .lu_vaddr_i   (fetch_vaddr_i),
    .lu_hit_o     (itlb_hit),
    .lu_pte_o     (itlb_pte),
    .lu_is_mega_o (itlb_mega)
  );

  assign miss_o.valid = fetch_req_i && en_i && !itlb_hit;
  assign miss_o.vpn   = fetch_vaddr_i[VADDR_W-1:PAGE_OFS_W];

  // not executable, supervisor page from U-mode or user page from S-mode
  assign perm_err = !itlb_pte.x
                    || ((priv_i == PRIV_U) && !itlb_pte.u)
                    || ((priv_i == PRIV_S) && itlb_pte.u);

  always_comb begin
    // translation off: pass through
    fetch_valid_o = fetch_req_i;
    fetch_paddr_o = PADDR_W'(fetch_vaddr_i);
    fetch_ex_o    = '0;
    if (en_i) begin
      fetch_valid_o = fetch_req_i && (itlb_hit || walk_err_i.valid);
      fetch_paddr_o = sv32_paddr(itlb_pte.ppn, itlb_mega, fetch_vaddr_i);
      if (fetch_req_i && itlb_hit && perm_err) begin
        fetch_ex_o = '{valid: 1'b1, cause: CAUSE_INSTR_PAGE, tval: fetch_vaddr_i};
      end else if (fetch_req_i && walk_err_i.valid) begin
        fetch_ex_o.valid = 1'b1;
        fetch_ex_o.cause = walk_err_i.access_fault ? CAUSE_INSTR_ACCESS : CAUSE_INSTR_PAGE;
        fetch_ex_o.tval  = fetch_vaddr_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/mmu_tlb.sv ====
// fully associative Sv32 TLB with megapage match, round-robin refill and flush
`timescale 1ns/1ns
`default_nettype none

module mmu_tlb
  import mmu_pkg::*;
#(
  parameter int unsigned ENTRIES = 4
) (
  input  wire         clk_i,
  input  wire         rst_ni,
  input  logic        flush_i,
  input  tlb_update_t update_i,
  input  vaddr_t      lu_vaddr_i,
  output logic        lu_hit_o,
  output pte_t        lu_pte_o,
  output logic        lu_is_mega_o
);

  logic [ENTRIES-1:0]         valid_q;
  logic [ENTRIES-1:0]         mega_q;
  vpn_t                       tag_q [ENTRIES];
  pte_t                       pte_q [ENTRIES];
  logic [ENTRIES-1:0]         match;
  logic [$clog2(ENTRIES)-1:0] rr_q;
  logic [$clog2(ENTRIES)-1:0] wr_idx;
  logic                       free_found;
  vpn_t                       lu_vpn;

  assign lu_vpn = lu_vaddr_i[VADDR_W-1:PAGE_OFS_W];

  // ------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      // megapages ignore VPN[0]
      match[i] = valid_q[i]
                 && (tag_q[i][VPN_W-1:VPN_LVL_W] == lu_vpn[VPN_W-1:VPN_LVL_W])
                 && (mega_q[i] || (tag_q[i][VPN_LVL_W-1:0] == lu_vpn[VPN_LVL_W-1:0]));
    end
  end

  always_comb begin
    lu_hit_o     = 1'b0;
    lu_pte_o     = '0;
    lu_is_mega_o = 1'b0;
    for (int i = 0; i < ENTRIES; i++) begin
      if (match[i]) begin
        lu_hit_o     = 1'b1;
        lu_pte_o     = pte_q[i];
        lu_is_mega_o = mega_q[i];
      end
    end
  end

  // ------------------------------------------------------------
  // refill slot: lowest free entry, else the round-robin victim
  // ------------------------------------------------------------
  always_comb begin
    free_found = 1'b0;
    wr_idx     = rr_q;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_found = 1'b1;
        wr_idx     = i[$clog2(ENTRIES)-1:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (update_i.valid) begin
      valid_q[wr_idx] <= 1'b1;
      if (!free_found) begin
        rr_q <= rr_q + 1'b1;
      end
    end
  end

  // entry contents
  always_ff @(posedge clk_i) begin
    if (update_i.valid && !flush_i) begin
      tag_q[wr_idx]  <= update_i.vpn;
      mega_q[wr_idx] <= update_i.is_mega;
      pte_q[wr_idx]  <= update_i.pte;
    end
  end

endmodule

`default_nettype wire

// ==== source/mmu_pkg.sv ====
// Sv32 MMU shared widths, types, exception causes and TLB sizes
`default_nettype none

package mmu_pkg;

  // ------------------------------------------------------------
  // widths and sizes
  // ------------------------------------------------------------
  localparam int unsigned VADDR_W    = 32;
  localparam int unsigned PADDR_W    = 34;
  localparam int unsigned VPN_W      = 20;
  localparam int unsigned PPN_W      = 22;
  localparam int unsigned PAGE_OFS_W = 12;
  // one level of the two-level Sv32 table
  localparam int unsigned VPN_LVL_W  = 10;

  localparam int unsigned ITLB_ENTRIES = 4;
  localparam int unsigned DTLB_ENTRIES = 8;

  // exception causes
  localparam logic [3:0] CAUSE_INSTR_ACCESS = 4'd1;
  localparam logic [3:0] CAUSE_LOAD_ACCESS  = 4'd5;
  localparam logic [3:0] CAUSE_STORE_ACCESS = 4'd7;
  localparam logic [3:0] CAUSE_INSTR_PAGE   = 4'd12;
  localparam logic [3:0] CAUSE_LOAD_PAGE    = 4'd13;
  localparam logic [3:0] CAUSE_STORE_PAGE   = 4'd15;

  // ------------------------------------------------------------
  // types
  // ------------------------------------------------------------
  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [VPN_W-1:0]   vpn_t;
  typedef logic [PPN_W-1:0]   ppn_t;
  typedef logic [1:0]         priv_lvl_t;

  localparam priv_lvl_t PRIV_U = 2'd0;
  localparam priv_lvl_t PRIV_S = 2'd1;
  localparam priv_lvl_t PRIV_M = 2'd3;

  typedef struct packed {
    ppn_t       ppn;
    logic [1:0] rsw;
    logic       d;
    logic       a;
    logic       g;
    logic       u;
    logic       x;
    logic       w;
    logic       r;
    logic       v;
  } pte_t;

  typedef struct packed {
    logic       valid;
    logic [3:0] cause;
    vaddr_t     tval;
  } exception_t;

  typedef struct packed {
    logic valid;
    vpn_t vpn;
    logic is_mega;
    pte_t pte;
  } tlb_update_t;

  typedef struct packed {
    logic valid;
    logic is_instr;
    vpn_t vpn;
  } refill_req_t;

  typedef struct packed {
    logic valid;
    pte_t pte;
    logic is_mega;
    logic page_fault;
    logic access_fault;
  } refill_rsp_t;

  // miss report from a translation path
  typedef struct packed {
    logic valid;
    vpn_t vpn;
  } miss_t;

  typedef struct packed {
    logic valid;
    logic page_fault;
    logic access_fault;
  } walk_err_t;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_I,
    WAIT_D
  } refill_state_e;

  // physical address from a leaf PTE, megapages keep VPN[0] of the virtual address
  function automatic paddr_t sv32_paddr(input ppn_t ppn, input logic is_mega,
                                        input vaddr_t vaddr);
    paddr_t pa;
    pa = {ppn, vaddr[PAGE_OFS_W-1:0]};
    if (is_mega) begin
      pa[PAGE_OFS_W+VPN_LVL_W-1:PAGE_OFS_W] = vaddr[PAGE_OFS_W+VPN_LVL_W-1:PAGE_OFS_W];
    end
    return pa;
  endfunction

endpackage

`default_nettype wire
